// File: riscvPkg.sv
// Shared encodings of the RV32IM control path, imported by every RTL block and the testbench.
package riscvPkg;

    // funct3 codes of the arithmetic and logic operations.
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // funct3 codes of the conditional branches.
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // funct3 codes of the load and store access widths.
    localparam logic [2:0] f3Byte  = 3'b000;
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3ByteU = 3'b100;
    localparam logic [2:0] f3HalfU = 3'b101;

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111
    } opcodeT;

    typedef enum logic [3:0] {
        sFetch, sDecode, sMemAdr, sMemRead, sMemWb, sMemWrite, sExecuteR, sExecuteI,
        sAluWb, sBranch, sJal, sJalr, sLui, sAuipc, sMulExt
    } fsmStateT;

    typedef enum logic [1:0] {resAluOut, resMemData, resAluResult, resMulExt} resultSrcT;
    typedef enum logic [1:0] {srcAPc, srcAOldPc, srcARs1} srcAT;
    typedef enum logic [1:0] {srcBRs2, srcBImm, srcBFour} srcBT;
    typedef enum logic [2:0] {immI, immS, immB, immJ, immU} immSrcT;
    typedef enum logic [1:0] {aluOpAdd, aluOpBranch, aluOpFunct, aluOpLui} aluOpT;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSll, aluSrl, aluSra, aluSlt, aluSltu,
        aluBeq, aluBne, aluBlt, aluBge, aluBltu, aluBgeu, aluPassB
    } aluCtrlT;

    typedef enum logic [2:0] {ldB, ldH, ldW, ldBu, ldHu, ldNone} loadOpT;
    typedef enum logic [1:0] {stB, stH, stW, stNone} storeOpT;
    // the operation order follows the low two funct3 bits.
    typedef enum logic [1:0] {mulMul, mulMulh, mulMulhsu, mulMulhu} mulOpT;
    typedef enum logic [1:0] {divDiv, divDivu, divRem, divRemu} divOpT;

endpackage

// File: unitReqIf.sv
// Valid/ready levels between the main FSM and the memory, ALU and multiply/divide unit ports.
`timescale 1ns/10ps

interface unitReqIf;
    logic memValid;    // memory request from fetch, load or store.
    logic memReady;
    logic aluValid;    // multicycle ALU request.
    logic aluReady;
    logic mulExtValid; // multiply or divide request, split later by funct3.
    logic mulExtReady;

    modport fsm (
        output memValid, aluValid, mulExtValid,
        input  memReady, aluReady, mulExtReady
    );

    modport top (
        input  memValid, aluValid, mulExtValid,
        output memReady, aluReady, mulExtReady
    );

endinterface

// File: mainFsm.sv
// Multicycle main FSM of the RV32IM core, instantiated by controlUnit to sequence each instruction.
`timescale 1ns/10ps

module mainFsm import riscvPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  opcodeT    op,
    input  logic      funct7b1,
    output logic      adrSrc,
    output logic      irWrite,
    output srcAT      aluSrcA,
    output srcBT      aluSrcB,
    output aluOpT     aluOp,
    output resultSrcT resultSrc,
    output immSrcT    immSrc,
    output logic      pcUpdate,
    output logic      branch,
    output logic      regWrite,
    output logic      aluOutWrite,
    output logic      memWrite,
    unitReqIf.fsm     req
);

    fsmStateT state;
    fsmStateT nextState;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state; // a waiting state holds until its ready level.
        case (state)
            sFetch:
                if (req.memReady)
                    nextState = sDecode;
            sDecode: begin
                case (op)
                    opLoad, opStore: nextState = sMemAdr;
                    opOp:            nextState = funct7b1 ? sMulExt : sExecuteR;
                    opOpImm:         nextState = sExecuteI;
                    opBranch:        nextState = sBranch;
                    opJal:           nextState = sJal;
                    opJalr:          nextState = sJalr;
                    opLui:           nextState = sLui;
                    opAuipc:         nextState = sAuipc;
                    default:         nextState = sFetch;
                endcase
            end
            sMemAdr:
                if (req.aluReady)
                    nextState = (op == opStore) ? sMemWrite : sMemRead;
            sMemRead:
                if (req.memReady)
                    nextState = sMemWb;
            sMemWrite, sBranch:
                if ((state == sMemWrite) ? req.memReady : req.aluReady)
                    nextState = sFetch;
            sExecuteR, sExecuteI:
                if (req.aluReady)
                    nextState = sAluWb;
            sMulExt:
                if (req.mulExtReady)
                    nextState = sAluWb;
            sJal, sJalr, sLui, sAuipc: nextState = sAluWb;
            default:                   nextState = sFetch; // covers sMemWb and sAluWb.
        endcase
    end

    always_comb begin
        adrSrc          = 1'b0;
        irWrite         = 1'b0;
        aluSrcA         = srcARs1;
        aluSrcB         = srcBRs2;
        aluOp           = aluOpAdd;
        resultSrc       = resAluOut;
        pcUpdate        = 1'b0;
        branch          = 1'b0;
        regWrite        = 1'b0;
        aluOutWrite     = 1'b0;
        memWrite        = 1'b0;
        req.memValid    = 1'b0;
        req.aluValid    = 1'b0;
        req.mulExtValid = 1'b0;
        case (state)
            sFetch: begin
                req.memValid = 1'b1;
                aluSrcA      = srcAPc;
                aluSrcB      = srcBFour;
                irWrite      = req.memReady; // instruction and pc + 4 land on the same edge.
                pcUpdate     = req.memReady;
            end
            sDecode: begin
                aluSrcA     = srcAOldPc; // branch and jump target goes into aluOut.
                aluSrcB     = srcBImm;
                aluOutWrite = 1'b1;
            end
            sMemAdr: begin
                req.aluValid = 1'b1;
                aluSrcB      = srcBImm;
                aluOutWrite  = 1'b1;
            end
            sMemRead: begin
                req.memValid = 1'b1;
                adrSrc       = 1'b1;
            end
            sMemWb: begin
                regWrite  = 1'b1;
                resultSrc = resMemData;
            end
            sMemWrite: begin
                req.memValid = 1'b1;
                memWrite     = 1'b1;
                adrSrc       = 1'b1;
            end
            sExecuteR, sExecuteI: begin
                req.aluValid = 1'b1;
                aluSrcB      = (state == sExecuteI) ? srcBImm : srcBRs2;
                aluOp        = aluOpFunct;
                aluOutWrite  = 1'b1;
            end
            sMulExt: req.mulExtValid = 1'b1;
            sAluWb: begin
                regWrite  = 1'b1;
                resultSrc = (op == opOp && funct7b1) ? resMulExt : resAluOut;
            end
            sBranch: begin
                req.aluValid = 1'b1;
                aluOp        = aluOpBranch;
                branch       = req.aluReady; // zero is only settled on the completing edge.
            end
            sJal: begin
                aluSrcA     = srcAOldPc;
                aluSrcB     = srcBFour;
                pcUpdate    = 1'b1; // pc takes the target held in aluOut.
                aluOutWrite = 1'b1;
            end
            sJalr: begin
                aluSrcB   = srcBImm;
                resultSrc = resAluResult;
                pcUpdate  = 1'b1;
            end
            sLui, sAuipc: begin
                aluSrcA     = (state == sAuipc) ? srcAOldPc : srcARs1;
                aluSrcB     = srcBImm;
                aluOp       = (state == sLui) ? aluOpLui : aluOpAdd;
                aluOutWrite = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (op)
            opStore:        immSrc = immS;
            opBranch:       immSrc = immB;
            opJal:          immSrc = immJ;
            opLui, opAuipc: immSrc = immU;
            default:        immSrc = immI; // loads, jalr and immediate arithmetic.
        endcase
    end

endmodule

// File: aluDecoder.sv
// ALU operation decoder of controlUnit, combining the FSM's aluOp class with the funct fields.
`timescale 1ns/10ps

module aluDecoder import riscvPkg::*; (
    input  logic       immB10,
    input  logic       opB5,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  aluOpT      aluOp,
    output aluCtrlT    aluControl
);

    always_comb begin
        aluControl = aluAdd; // pc and address arithmetic.
        case (aluOp)
            aluOpLui: aluControl = aluPassB;
            aluOpBranch: begin
                case (funct3)
                    f3Beq:   aluControl = aluBeq;
                    f3Bne:   aluControl = aluBne;
                    f3Blt:   aluControl = aluBlt;
                    f3Bge:   aluControl = aluBge;
                    f3Bltu:  aluControl = aluBltu;
                    f3Bgeu:  aluControl = aluBgeu;
                    default: aluControl = aluAdd;
                endcase
            end
            aluOpFunct: begin
                case (funct3)
                    // immediate arithmetic has no subtract, so op bit 5 gates funct7b5.
                    f3AddSub: aluControl = (opB5 && funct7b5) ? aluSub : aluAdd;
                    f3Sll:    aluControl = aluSll;
                    f3Slt:    aluControl = aluSlt;
                    f3Sltu:   aluControl = aluSltu;
                    f3Xor:    aluControl = aluXor;
                    f3SrlSra: aluControl = immB10 ? aluSra : aluSrl;
                    f3Or:     aluControl = aluOr;
                    default:  aluControl = aluAnd;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: memOpDecoder.sv
// Load and store width decoder of controlUnit, both driven from the same funct3 field.
`timescale 1ns/10ps

module memOpDecoder import riscvPkg::*; (
    input  logic [2:0] funct3,
    output loadOpT     loadOp,
    output storeOpT    storeOp
);

    always_comb begin
        case (funct3)
            f3Byte:  loadOp = ldB;
            f3Half:  loadOp = ldH;
            f3Word:  loadOp = ldW;
            f3ByteU: loadOp = ldBu; // zero-extended byte.
            f3HalfU: loadOp = ldHu;
            default: loadOp = ldNone;
        endcase
    end

    always_comb begin
        case (funct3)
            f3Byte:  storeOp = stB;
            f3Half:  storeOp = stH;
            f3Word:  storeOp = stW;
            default: storeOp = stNone; // stores have no unsigned forms.
        endcase
    end

endmodule

// File: mulExtDecoder.sv
// Multiply/divide decoder of controlUnit, splitting the FSM's request between the two units.
`timescale 1ns/10ps

module mulExtDecoder import riscvPkg::*; (
    input  logic [2:0] funct3,
    input  logic       mulExtValid,
    output mulOpT      mulOp,
    output divOpT      divOp,
    output logic       mulValid,
    output logic       divValid
);

    assign mulValid = mulExtValid && !funct3[2]; // funct3 100 to 111 are divides.
    assign divValid = mulExtValid && funct3[2];

    always_comb begin
        case (funct3[1:0])
            2'b00:   mulOp = mulMul;
            2'b01:   mulOp = mulMulh;
            2'b10:   mulOp = mulMulhsu;
            default: mulOp = mulMulhu;
        endcase
    end

    always_comb begin
        case (funct3[1:0])
            2'b00:   divOp = divDiv;
            2'b01:   divOp = divDivu;
            2'b10:   divOp = divRem;
            default: divOp = divRemu;
        endcase
    end

endmodule

// File: controlUnit.sv
// Top level of the RV32IM multicycle control path, driven by the instruction register fields.
`timescale 1ns/10ps

module controlUnit import riscvPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  opcodeT     op,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  logic       funct7b1,
    input  logic       immB10,
    input  logic       zero,
    output resultSrcT  resultSrc,
    output aluCtrlT    aluControl,
    output srcAT       aluSrcA,
    output srcBT       aluSrcB,
    output immSrcT     immSrc,
    output storeOpT    storeOp,
    output loadOpT     loadOp,
    output mulOpT      mulOp,
    output divOpT      divOp,
    output logic       regWrite,
    output logic       pcWrite,
    output logic       adrSrc,
    output logic       memWrite,
    output logic       irWrite,
    output logic       aluOutWrite,
    output logic       memValid,
    input  logic       memReady,
    output logic       aluValid,
    input  logic       aluReady,
    output logic       mulValid,
    input  logic       mulReady,
    output logic       divValid,
    input  logic       divReady
);

    aluOpT aluOp;
    logic  pcUpdate;
    logic  branch;

    unitReqIf req ();

    assign req.memReady    = memReady;
    assign req.aluReady    = aluReady;
    assign req.mulExtReady = mulReady || divReady; // only the addressed unit answers.
    assign memValid        = req.memValid;
    assign aluValid        = req.aluValid;

    assign pcWrite = (branch && !zero) || pcUpdate; // a branch is taken when the compare is false.

    mainFsm mainFsm_i (
        .clk         (clk),
        .rst         (rst),
        .op          (op),
        .funct7b1    (funct7b1),
        .adrSrc      (adrSrc),
        .irWrite     (irWrite),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .resultSrc   (resultSrc),
        .immSrc      (immSrc),
        .pcUpdate    (pcUpdate),
        .branch      (branch),
        .regWrite    (regWrite),
        .aluOutWrite (aluOutWrite),
        .memWrite    (memWrite),
        .req         (req.fsm)
    );

    aluDecoder aluDecoder_i (
        .immB10     (immB10),
        .opB5       (op[5]),
        .funct3     (funct3),
        .funct7b5   (funct7b5),
        .aluOp      (aluOp),
        .aluControl (aluControl)
    );

    memOpDecoder memOpDecoder_i (
        .funct3  (funct3),
        .loadOp  (loadOp),
        .storeOp (storeOp)
    );

    mulExtDecoder mulExtDecoder_i (
        .funct3      (funct3),
        .mulExtValid (req.mulExtValid),
        .mulOp       (mulOp),
        .divOp       (divOp),
        .mulValid    (mulValid),
        .divValid    (divValid)
    );

endmodule

// File: tbControlUnit.sv
// Self-checking testbench of controlUnit with random instructions and ready levels, built from sim.f.
`timescale 1ns/10ps

module tbControlUnit import riscvPkg::*; ();

    logic       clk = 1'b0;
    logic       rst;
    opcodeT     op;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       funct7b1;
    logic       immB10;
    logic       zero;
    resultSrcT  resultSrc;
    aluCtrlT    aluControl;
    srcAT       aluSrcA;
    srcBT       aluSrcB;
    immSrcT     immSrc;
    storeOpT    storeOp;
    loadOpT     loadOp;
    mulOpT      mulOp;
    divOpT      divOp;
    logic       regWrite;
    logic       pcWrite;
    logic       adrSrc;
    logic       memWrite;
    logic       irWrite;
    logic       aluOutWrite;
    logic       memValid;
    logic       memReady;
    logic       aluValid;
    logic       aluReady;
    logic       mulValid;
    logic       mulReady;
    logic       divValid;
    logic       divReady;

    fsmStateT modelState; // shadow of the DUT's main FSM state.
    fsmStateT prevState;  // shadow state of the previous cycle.
    logic     running;
    int       retired;    // instructions that returned to fetch.
    int       transfers;  // handshakes of the instruction in flight.

    controlUnit controlUnit_i (.*);

    always #20 clk = ~clk;

    task automatic stopWithError(string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic checkStrobe(string name, logic got, logic exp);
        if (got !== exp)
            stopWithError($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic checkAluCtrl(aluCtrlT got, aluCtrlT exp);
        if (got !== exp)
            stopWithError($sformatf("mismatch aluControl: got %h expected %h", got, exp));
    endtask

    task automatic checkLoadOp(loadOpT got, loadOpT exp);
        if (got !== exp)
            stopWithError($sformatf("mismatch loadOp: got %h expected %h", got, exp));
    endtask

    task automatic checkStoreOp(storeOpT got, storeOpT exp);
        if (got !== exp)
            stopWithError($sformatf("mismatch storeOp: got %h expected %h", got, exp));
    endtask

    task automatic checkMulOp(mulOpT got, mulOpT exp);
        if (got !== exp)
            stopWithError($sformatf("mismatch mulOp: got %h expected %h", got, exp));
    endtask

    task automatic checkDivOp(divOpT got, divOpT exp);
        if (got !== exp)
            stopWithError($sformatf("mismatch divOp: got %h expected %h", got, exp));
    endtask

    task automatic checkSrcA(srcAT got, srcAT exp);
        if (got !== exp)
            stopWithError($sformatf("mismatch aluSrcA: got %h expected %h", got, exp));
    endtask

    task automatic checkSrcB(srcBT got, srcBT exp);
        if (got !== exp)
            stopWithError($sformatf("mismatch aluSrcB: got %h expected %h", got, exp));
    endtask

    task automatic checkResultSrc(resultSrcT got, resultSrcT exp);
        if (got !== exp)
            stopWithError($sformatf("mismatch resultSrc: got %h expected %h", got, exp));
    endtask

    task automatic checkImmSrc(immSrcT got, immSrcT exp);
        if (got !== exp)
            stopWithError($sformatf("mismatch immSrc: got %h expected %h", got, exp));
    endtask

    function automatic fsmStateT nextStateOf(fsmStateT s);
        fsmStateT n;
        n = s; // waiting states hold until their ready level.
        case (s)
            sFetch:               n = memReady ? sDecode : s;
            sDecode: begin
                case (op)
                    opLoad, opStore: n = sMemAdr;
                    opOp:            n = funct7b1 ? sMulExt : sExecuteR;
                    opOpImm:         n = sExecuteI;
                    opBranch:        n = sBranch;
                    opJal:           n = sJal;
                    opJalr:          n = sJalr;
                    opLui:           n = sLui;
                    default:         n = sAuipc;
                endcase
            end
            sMemAdr:              n = !aluReady ? s : ((op == opStore) ? sMemWrite : sMemRead);
            sMemRead:             n = memReady ? sMemWb : s;
            sMemWrite:            n = memReady ? sFetch : s;
            sBranch:              n = aluReady ? sFetch : s;
            sExecuteR, sExecuteI: n = aluReady ? sAluWb : s;
            sMulExt:              n = (funct3[2] ? divReady : mulReady) ? sAluWb : s;
            sJal, sJalr, sLui, sAuipc: n = sAluWb;
            default:              n = sFetch; // writeback states last one cycle.
        endcase
        return n;
    endfunction

    function automatic aluCtrlT expectedAluCtrl(fsmStateT s);
        aluCtrlT c;
        c = aluAdd;
        if (s == sLui) begin
            c = aluPassB;
        end else if (s == sBranch) begin
            case (funct3)
                3'b000:  c = aluBeq;
                3'b001:  c = aluBne;
                3'b100:  c = aluBlt;
                3'b101:  c = aluBge;
                3'b110:  c = aluBltu;
                default: c = aluBgeu;
            endcase
        end else if (s == sExecuteR || s == sExecuteI) begin
            case (funct3)
                3'b000:  c = (op[5] && funct7b5) ? aluSub : aluAdd;
                3'b001:  c = aluSll;
                3'b010:  c = aluSlt;
                3'b011:  c = aluSltu;
                3'b100:  c = aluXor;
                3'b101:  c = immB10 ? aluSra : aluSrl;
                3'b110:  c = aluOr;
                default: c = aluAnd;
            endcase
        end
        return c;
    endfunction

    function automatic loadOpT expectedLoadOp(logic [2:0] f);
        case (f)
            3'b000:  return ldB;
            3'b001:  return ldH;
            3'b010:  return ldW;
            3'b100:  return ldBu;
            3'b101:  return ldHu;
            default: return ldNone;
        endcase
    endfunction

    function automatic storeOpT expectedStoreOp(logic [2:0] f);
        case (f)
            3'b000:  return stB;
            3'b001:  return stH;
            3'b010:  return stW;
            default: return stNone;
        endcase
    endfunction

    // immediate format of each RV32 instruction class.
    function automatic immSrcT expectedImmSrc(opcodeT o);
        case (o)
            opStore:        return immS;
            opBranch:       return immB;
            opJal:          return immJ;
            opLui, opAuipc: return immU;
            default:        return immI;
        endcase
    endfunction

    function automatic int transfersOf(opcodeT o);
        case (o)
            opLoad, opStore:         return 3; // fetch, address and data access.
            opOp, opOpImm, opBranch: return 2;
            default:                 return 1;
        endcase
    endfunction

    task automatic drawInstruction();
        opcodeT     o;
        logic [2:0] f;
        o = o.first();
        repeat ($urandom_range(8))
            o = o.next();
        f = $urandom_range(7);
        if (o == opBranch && f[2:1] == 2'b01)
            f[1] = 1'b0; // branches have no funct3 010 or 011.
        op       <= o;
        funct3   <= f;
        funct7b5 <= $urandom_range(1);
        funct7b1 <= $urandom_range(1);
        immB10   <= $urandom_range(1);
        zero     <= $urandom_range(1);
    endtask

    task automatic compareOutputs();
        fsmStateT s;
        logic     expPc;
        s = modelState;
        expPc = (s == sFetch && memReady) || (s == sBranch && aluReady && !zero) ||
                s == sJal || s == sJalr;
        checkStrobe("memValid", memValid, s == sFetch || s == sMemRead || s == sMemWrite);
        checkStrobe("aluValid", aluValid,
                    s == sMemAdr || s == sExecuteR || s == sExecuteI || s == sBranch);
        checkStrobe("mulValid", mulValid, s == sMulExt && !funct3[2]);
        checkStrobe("divValid", divValid, s == sMulExt && funct3[2]);
        checkStrobe("irWrite", irWrite, s == sFetch && memReady);
        checkStrobe("pcWrite", pcWrite, expPc);
        checkStrobe("regWrite", regWrite, s == sMemWb || s == sAluWb);
        checkStrobe("memWrite", memWrite, s == sMemWrite);
        checkStrobe("adrSrc", adrSrc, s == sMemRead || s == sMemWrite);
        if (s == sFetch || s == sDecode)
            checkStrobe("aluOutWrite", aluOutWrite, s == sDecode);
        if (s == sFetch) begin
            checkSrcA(aluSrcA, srcAPc);
            checkSrcB(aluSrcB, srcBFour);
        end else if (s == sDecode) begin
            checkSrcA(aluSrcA, srcAOldPc);
            checkSrcB(aluSrcB, srcBImm);
        end else if (s == sMemAdr) begin
            checkSrcA(aluSrcA, srcARs1);
            checkSrcB(aluSrcB, srcBImm);
        end
        if (s == sMemWb)
            checkResultSrc(resultSrc, resMemData);
        else if (s == sAluWb)
            checkResultSrc(resultSrc, (prevState == sMulExt) ? resMulExt : resAluOut);
        checkImmSrc(immSrc, expectedImmSrc(op));
        checkAluCtrl(aluControl, expectedAluCtrl(s));
        checkLoadOp(loadOp, expectedLoadOp(funct3));
        checkStoreOp(storeOp, expectedStoreOp(funct3));
        checkMulOp(mulOp, mulOpT'(funct3[1:0]));
        checkDivOp(divOp, divOpT'(funct3[1:0]));
        if ((memValid && memReady) || (aluValid && aluReady) ||
            (mulValid && mulReady) || (divValid && divReady))
            transfers++;
    endtask

    // the model steps on the same edge as the DUT, using the ready levels of the ending cycle.
    always @(posedge clk) begin
        fsmStateT n;
        if (running) begin
            n = nextStateOf(modelState);
            if (modelState == sFetch && n == sDecode)
                drawInstruction(); // the instruction register loads on this edge.
            if (modelState != sFetch && n == sFetch) begin
                if (transfers != transfersOf(op))
                    stopWithError($sformatf("mismatch transfers: got %h expected %h",
                                            transfers, transfersOf(op)));
                transfers = 0;
                retired++;
            end
            prevState  = modelState;
            modelState = n;
            memReady <= ($urandom_range(2) == 0);
            aluReady <= ($urandom_range(2) == 0);
            mulReady <= (n == sMulExt) && !funct3[2] && ($urandom_range(2) == 0);
            divReady <= (n == sMulExt) && funct3[2] && ($urandom_range(2) == 0);
        end
    end

    always @(negedge clk) begin
        if (running)
            compareOutputs();
    end

    initial begin
        int waited;
        void'($urandom(32'h1791));
        rst        = 1'b1;
        running    = 1'b0;
        retired    = 0;
        transfers  = 0;
        modelState = sFetch;
        prevState  = sFetch;
        op         = opLoad;
        funct3     = 3'b000;
        funct7b5   = 1'b0;
        funct7b1   = 1'b0;
        immB10     = 1'b0;
        zero       = 1'b0;
        memReady   = 1'b0;
        aluReady   = 1'b0;
        mulReady   = 1'b0;
        divReady   = 1'b0;
        repeat (16) @(posedge clk);
        rst     <= 1'b0;
        running <= 1'b1;
        for (int i = 1; i <= 300; i++) begin
            waited = 0;
            while (retired < i) begin
                @(negedge clk);
                waited++;
                if (waited > 200)
                    stopWithError($sformatf("timeout: instruction %0d never returned to fetch", i));
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: sim.f
riscvPkg.sv
unitReqIf.sv
mainFsm.sv
aluDecoder.sv
memOpDecoder.sv
mulExtDecoder.sv
controlUnit.sv
tbControlUnit.sv
